// ==== filelist.f ====
+incdir+include
design/tile_pkg.sv
design/noc_rx_stage.sv
design/tcu_cmd_decode.sv
design/spm_bank.sv
design/tile_regfile.sv
design/mem_access_stage.sv
design/noc_tx_stage.sv
design/acc_tile_top.sv
testbench/tile_checker.sv
testbench/tb_acc_tile.sv

// ==== testbench/tb_acc_tile.sv ====
`timescale 1ns/1ps
`include "tile_config.svh"

module tb_acc_tile;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_PACKETS = 110;
    localparam int WATCHDOG_CYCLES = NUM_PACKETS * 20 + 200;
    localparam int DMEM_SLOTS  = 16;
    localparam int ACC_SLOTS   = 8;

    logic                       clk_pm;
    logic                       rst_n;
    logic                       rx_wrreq;
    logic [`NOC_MODE_BITS-1:0]  rx_mode;
    logic [`NOC_ADDR_BITS-1:0]  rx_addr;
    logic [`NOC_DATA_BITS-1:0]  rx_data;
    logic [`NOC_BSEL_BITS-1:0]  rx_bsel;
    logic [`NOC_MODID_BITS-1:0] rx_src_modid;
    logic [`NOC_MODID_BITS-1:0] rx_trg_modid;
    logic                       rx_stall;
    logic                       tx_stall;
    logic                       tx_wrreq;
    logic [`NOC_MODE_BITS-1:0]  tx_mode;
    logic [`NOC_ADDR_BITS-1:0]  tx_addr;
    logic [`NOC_DATA_BITS-1:0]  tx_data;
    logic [`NOC_MODID_BITS-1:0] tx_trg_modid;
    logic                       asm_en;
    logic                       acc_en;
    logic                       stall_random;
    logic                       stall_hold;
    integer                     seed;
    int                         err_cnt;
    int                         pending;
    logic [`NOC_ADDR_BITS-1:0]  dmem_addrs [DMEM_SLOTS];
    logic [`NOC_ADDR_BITS-1:0]  acc_addrs [ACC_SLOTS];

    acc_tile_top dut_i (
        .clk_pm_i (clk_pm), .rst_n_i (rst_n),
        .rx_wrreq_i (rx_wrreq), .rx_mode_i (rx_mode), .rx_addr_i (rx_addr),
        .rx_data_i (rx_data), .rx_bsel_i (rx_bsel), .rx_src_modid_i (rx_src_modid),
        .rx_trg_modid_i (rx_trg_modid), .rx_stall_o (rx_stall), .tx_stall_i (tx_stall),
        .tx_wrreq_o (tx_wrreq), .tx_mode_o (tx_mode), .tx_addr_o (tx_addr),
        .tx_data_o (tx_data), .tx_trg_modid_o (tx_trg_modid),
        .asm_en_o (asm_en), .acc_en_o (acc_en)
    );

    tile_checker chk_i (
        .clk_i (clk_pm), .rst_n_i (rst_n),
        .rx_wrreq_i (rx_wrreq), .rx_mode_i (rx_mode), .rx_addr_i (rx_addr),
        .rx_data_i (rx_data), .rx_bsel_i (rx_bsel), .rx_src_modid_i (rx_src_modid),
        .rx_trg_modid_i (rx_trg_modid), .rx_stall_i (rx_stall), .tx_stall_i (tx_stall),
        .tx_wrreq_i (tx_wrreq), .tx_mode_i (tx_mode), .tx_addr_i (tx_addr),
        .tx_data_i (tx_data), .tx_trg_modid_i (tx_trg_modid),
        .asm_en_i (asm_en), .acc_en_i (acc_en), .err_cnt_o (err_cnt), .pending_o (pending)
    );

    initial begin
        clk_pm = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pm = ~clk_pm;
    end

    always @(negedge clk_pm) begin
        if (stall_hold) begin
            tx_stall = 1'b1;
        end else begin
            tx_stall = stall_random ? (($random(seed) & 3) < 2) : 1'b0;   // about half stalled
        end
    end

    task automatic send_packet(input logic [3:0] mode, input logic [31:0] addr,
                               input logic [63:0] data, input logic [7:0] bsel,
                               input logic [7:0] src, input logic [7:0] trg);
        logic taken;
        @(negedge clk_pm);
        rx_wrreq     = 1'b1;
        rx_mode      = mode;
        rx_addr      = addr;
        rx_data      = data;
        rx_bsel      = bsel;
        rx_src_modid = src;
        rx_trg_modid = trg;
        taken        = 1'b0;
        while (!taken) begin
            @(posedge clk_pm);
            taken = !rx_stall;
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] bsel);
        send_packet(`MODE_WRITE, addr, data, bsel, 8'h10, `TILE_HOME_MODID);
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [7:0] src);
        send_packet(`MODE_READ_REQ, addr, 64'h0, 8'h00, src, `TILE_HOME_MODID);
    endtask

    // stop sending and wait until every expected response came back
    task automatic drain();
        @(negedge clk_pm);
        rx_wrreq = 1'b0;
        wait (pending == 0);
        @(negedge clk_pm);
    endtask

    initial begin
        seed = 39;
        rst_n = 1'b0;
        rx_wrreq = 1'b0;
        rx_mode = '0;
        rx_addr = '0;
        rx_data = '0;
        rx_bsel = '0;
        rx_src_modid = '0;
        rx_trg_modid = '0;
        tx_stall = 1'b0;
        stall_random = 1'b0;
        stall_hold = 1'b0;
        repeat (5) @(posedge clk_pm);
        @(negedge clk_pm);
        rst_n = 1'b1;

        for (int i = 0; i < DMEM_SLOTS; i++) begin
            dmem_addrs[i] = `DMEM_START + (($random(seed) & (`DMEM_WORDS - 1)) << 3);
            write_word(dmem_addrs[i], {$random(seed), $random(seed)}, 8'hFF);
        end
        for (int i = 0; i < DMEM_SLOTS; i++) read_word(dmem_addrs[i], 8'h30 + i);
        drain();

        for (int i = 0; i < ACC_SLOTS; i++) begin
            acc_addrs[i] = `ACCMEM_START + (((i * 29 + 5) % `ACCMEM_WORDS) << 2);
            write_word(acc_addrs[i], {$random(seed), $random(seed)}, 8'h0F);
        end
        for (int i = 0; i < ACC_SLOTS; i++) begin
            write_word(acc_addrs[i], {$random(seed), $random(seed)}, $random(seed) & 8'hF6);
        end
        for (int i = 0; i < ACC_SLOTS; i++) read_word(acc_addrs[i], 8'h40 + i);
        drain();

        write_word(`CONFIG_START, 64'h3, 8'h01);
        read_word(`CONFIG_START, 8'h50);
        drain();
        chk_i.check_enables();
        write_word(`CONFIG_START, 64'h1, 8'hFF);
        write_word(`CONFIG_START + 8, 64'hFFFF, 8'hFF);   // counter is read-only
        read_word(`CONFIG_START, 8'h51);
        read_word(`CONFIG_START + 8, 8'h52);
        read_word(32'h0000_2000, 8'h53);
        read_word(32'h8000_0000, 8'h54);
        drain();
        chk_i.check_enables();

        // foreign target ids
        send_packet(`MODE_WRITE, dmem_addrs[0], 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, 8'h10, 8'h22);
        send_packet(`MODE_WRITE, acc_addrs[0], 64'h1234_5678, 8'h0F, 8'h10, 8'h00);
        send_packet(`MODE_READ_REQ, dmem_addrs[1], 64'h0, 8'h00, 8'h60, 8'h22);
        read_word(dmem_addrs[0], 8'h61);
        read_word(acc_addrs[0], 8'h62);
        drain();

        // four reads fill the four stages behind a stalled output
        stall_hold = 1'b1;
        for (int i = 0; i < 4; i++) read_word(dmem_addrs[i], 8'h68 + i);
        @(negedge clk_pm);
        rx_wrreq = 1'b0;
        chk_i.check_rx_stall(1'b1);
        stall_hold = 1'b0;
        drain();

        stall_random = 1'b1;
        for (int i = 0; i < 32; i++) begin
            if (i % 2) read_word(acc_addrs[i % ACC_SLOTS], 8'h70 + i);
            else read_word(dmem_addrs[i % DMEM_SLOTS], 8'h70 + i);
        end
        drain();
        stall_random = 1'b0;
        repeat (10) @(negedge clk_pm);   // catch late duplicates

        chk_i.print_summary();
        if (err_cnt == 0 && pending == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        chk_i.print_summary();
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== testbench/tile_checker.sv ====
`timescale 1ns/1ps
`include "tile_config.svh"

module tile_checker (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       rx_wrreq_i,
    input  logic [`NOC_MODE_BITS-1:0]  rx_mode_i,
    input  logic [`NOC_ADDR_BITS-1:0]  rx_addr_i,
    input  logic [`NOC_DATA_BITS-1:0]  rx_data_i,
    input  logic [`NOC_BSEL_BITS-1:0]  rx_bsel_i,
    input  logic [`NOC_MODID_BITS-1:0] rx_src_modid_i,
    input  logic [`NOC_MODID_BITS-1:0] rx_trg_modid_i,
    input  logic                       rx_stall_i,
    input  logic                       tx_stall_i,
    input  logic                       tx_wrreq_i,
    input  logic [`NOC_MODE_BITS-1:0]  tx_mode_i,
    input  logic [`NOC_ADDR_BITS-1:0]  tx_addr_i,
    input  logic [`NOC_DATA_BITS-1:0]  tx_data_i,
    input  logic [`NOC_MODID_BITS-1:0] tx_trg_modid_i,
    input  logic                       asm_en_i,
    input  logic                       acc_en_i,
    output int                         err_cnt_o,
    output int                         pending_o
);

    localparam int R_DMEM = 0;
    localparam int R_ACC  = 1;
    localparam int R_CFG  = 2;
    localparam int R_NONE = 3;

    logic [`NOC_DATA_BITS-1:0]  dmem_model [`DMEM_WORDS];
    logic [`ACC_WORD_BITS-1:0]  acc_model [`ACCMEM_WORDS];
    logic [1:0]                 ctrl_model;
    logic [15:0]                wcnt_model;
    logic [`NOC_ADDR_BITS-1:0]  exp_addr_q [$];
    logic [`NOC_DATA_BITS-1:0]  exp_data_q [$];
    logic [`NOC_MODID_BITS-1:0] exp_modid_q [$];
    int errors = 0;
    int responses = 0;
    int pending = 0;

    assign err_cnt_o = errors;
    assign pending_o = pending;

    function automatic int region_of(input logic [`NOC_ADDR_BITS-1:0] addr);
        if (addr >= `DMEM_START && addr < `DMEM_START + `DMEM_WORDS * 8) return R_DMEM;
        if (addr >= `ACCMEM_START && addr < `ACCMEM_START + `ACCMEM_WORDS * 4) return R_ACC;
        if (addr >= `CONFIG_START && addr < `CONFIG_START + `CONFIG_REGS * 8) return R_CFG;
        return R_NONE;
    endfunction

    function automatic int word_index(input logic [`NOC_ADDR_BITS-1:0] addr, input int region);
        case (region)
            R_DMEM:  return (addr - `DMEM_START) >> 3;
            R_ACC:   return (addr - `ACCMEM_START) >> 2;
            R_CFG:   return (addr - `CONFIG_START) >> 3;   // 8-byte registers
            default: return 0;
        endcase
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0] bsel);
        logic [63:0] res;
        res = old_word;
        for (int b = 0; b < 8; b++) begin
            if (bsel[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

    // what a read of addr must return given the model state
    function automatic logic [63:0] expected_read(input logic [`NOC_ADDR_BITS-1:0] addr);
        int region;
        int idx;
        region = region_of(addr);
        idx    = word_index(addr, region);
        case (region)
            R_DMEM:  return dmem_model[idx];
            R_ACC:   return {32'h0, acc_model[idx]};
            R_CFG:   return (idx == 0) ? {62'h0, ctrl_model} : {48'h0, wcnt_model};
            default: return 64'h0;
        endcase
    endfunction

    task automatic apply_packet();
        int          region;
        int          idx;
        logic [63:0] merged;
        region = region_of(rx_addr_i);
        idx    = word_index(rx_addr_i, region);
        if (rx_mode_i == `MODE_READ_REQ) begin
            exp_addr_q.push_back(rx_addr_i);
            exp_data_q.push_back(expected_read(rx_addr_i));
            exp_modid_q.push_back(rx_src_modid_i);
        end else if (rx_mode_i == `MODE_WRITE) begin
            if (region == R_DMEM) begin
                dmem_model[idx] = merge_bytes(dmem_model[idx], rx_data_i, rx_bsel_i);
                wcnt_model      = wcnt_model + 16'd1;
            end else if (region == R_ACC) begin
                merged         = merge_bytes({32'h0, acc_model[idx]}, rx_data_i,
                                             rx_bsel_i & 8'h0F);   // low bytes of the 32-bit word
                acc_model[idx] = merged[31:0];
                wcnt_model     = wcnt_model + 16'd1;
            end else if (region == R_CFG && idx == 0) begin
                ctrl_model = rx_data_i[1:0];   // whole word regardless of bsel
            end
        end
    endtask

    task automatic check_response();
        logic [`NOC_ADDR_BITS-1:0]  e_addr;
        logic [`NOC_DATA_BITS-1:0]  e_data;
        logic [`NOC_MODID_BITS-1:0] e_modid;
        if (exp_addr_q.size() == 0) begin
            errors++;
            $display("tx sent a packet to addr %h while no read was outstanding", tx_addr_i);
        end else begin
            e_addr  = exp_addr_q.pop_front();
            e_data  = exp_data_q.pop_front();
            e_modid = exp_modid_q.pop_front();
            responses++;
            if (tx_mode_i !== `MODE_READ_RESP) begin
                errors++;
                $display("CHECK FAILED tx_mode_o: got %h expected %h", tx_mode_i, `MODE_READ_RESP);
            end
            if (tx_addr_i !== e_addr) begin
                errors++;
                $display("CHECK FAILED tx_addr_o: got %h expected %h", tx_addr_i, e_addr);
            end
            if (tx_data_i !== e_data) begin
                errors++;
                $display("CHECK FAILED tx_data_o: got %h expected %h", tx_data_i, e_data);
            end
            if (tx_trg_modid_i !== e_modid) begin
                errors++;
                $display("CHECK FAILED tx_trg_modid_o: got %h expected %h", tx_trg_modid_i,
                         e_modid);
            end
        end
    endtask

    // only valid once every earlier write has left the pipeline
    task automatic check_enables();
        if (asm_en_i !== ctrl_model[0]) begin
            errors++;
            $display("CHECK FAILED asm_en_o: got %h expected %h", asm_en_i, ctrl_model[0]);
        end
        if (acc_en_i !== ctrl_model[1]) begin
            errors++;
            $display("CHECK FAILED acc_en_o: got %h expected %h", acc_en_i, ctrl_model[1]);
        end
    endtask

    task automatic check_rx_stall(input logic exp_stall);
        if (rx_stall_i !== exp_stall) begin
            errors++;
            $display("CHECK FAILED rx_stall_o: got %h expected %h", rx_stall_i, exp_stall);
        end
    endtask

    task automatic print_summary();
        $display("tile checker: %0d responses checked, %0d errors, %0d responses missing",
                 responses, errors, pending);
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_model = 2'b00;
            wcnt_model = 16'h0;
            exp_addr_q.delete();
            exp_data_q.delete();
            exp_modid_q.delete();
        end else begin
            if (tx_wrreq_i && !tx_stall_i) check_response();   // older items first
            if (rx_wrreq_i && !rx_stall_i && rx_trg_modid_i == `TILE_HOME_MODID) begin
                apply_packet();
            end
        end
        pending = exp_addr_q.size();
    end

endmodule

// ==== design/acc_tile_top.sv ====
`timescale 1ns/1ps

module acc_tile_top (
    input  logic                   clk_pm_i,
    input  logic                   rst_n_i,
    input  logic                   rx_wrreq_i,
    input  tile_pkg::noc_mode_t    rx_mode_i,
    input  tile_pkg::noc_addr_t    rx_addr_i,
    input  tile_pkg::noc_data_t    rx_data_i,
    input  tile_pkg::noc_bsel_t    rx_bsel_i,
    input  tile_pkg::noc_modid_t   rx_src_modid_i,
    input  tile_pkg::noc_modid_t   rx_trg_modid_i,
    output logic                   rx_stall_o,
    input  logic                   tx_stall_i,
    output logic                   tx_wrreq_o,
    output tile_pkg::noc_mode_t    tx_mode_o,
    output tile_pkg::noc_addr_t    tx_addr_o,
    output tile_pkg::noc_data_t    tx_data_o,
    output tile_pkg::noc_modid_t   tx_trg_modid_o,
    output logic                   asm_en_o,
    output logic                   acc_en_o
);

    // receive -> decode
    logic                 rx_q_valid;
    tile_pkg::noc_mode_t  rx_q_mode;
    tile_pkg::noc_addr_t  rx_q_addr;
    tile_pkg::noc_data_t  rx_q_data;
    tile_pkg::noc_bsel_t  rx_q_bsel;
    tile_pkg::noc_modid_t rx_q_src_modid;

    // decode -> memory
    logic                 dec_stall;
    logic                 dec_valid;
    tile_pkg::region_t    dec_region;
    logic                 dec_is_read;
    tile_pkg::noc_addr_t  dec_word_idx;
    tile_pkg::noc_data_t  dec_data;
    tile_pkg::noc_bsel_t  dec_bsel;
    tile_pkg::noc_addr_t  dec_rsp_addr;
    tile_pkg::noc_modid_t dec_rsp_modid;

    // memory -> transmit
    logic                 rsp_stall;
    logic                 rsp_valid;
    tile_pkg::noc_data_t  rsp_data;
    tile_pkg::noc_addr_t  rsp_addr;
    tile_pkg::noc_modid_t rsp_modid;
    logic                 tx_q_stall;

    noc_rx_stage rx_stage_i (
        .clk_pm_i (clk_pm_i), .rst_n_i (rst_n_i),
        .rx_wrreq_i (rx_wrreq_i), .rx_mode_i (rx_mode_i), .rx_addr_i (rx_addr_i),
        .rx_data_i (rx_data_i), .rx_bsel_i (rx_bsel_i),
        .rx_src_modid_i (rx_src_modid_i), .rx_trg_modid_i (rx_trg_modid_i),
        .stall_i (dec_stall), .rx_stall_o (rx_stall_o),
        .valid_o (rx_q_valid), .mode_o (rx_q_mode), .addr_o (rx_q_addr),
        .data_o (rx_q_data), .bsel_o (rx_q_bsel), .src_modid_o (rx_q_src_modid)
    );

    tcu_cmd_decode decode_i (
        .clk_pm_i (clk_pm_i), .rst_n_i (rst_n_i),
        .valid_i (rx_q_valid), .mode_i (rx_q_mode), .addr_i (rx_q_addr),
        .data_i (rx_q_data), .bsel_i (rx_q_bsel), .src_modid_i (rx_q_src_modid),
        .stall_i (rsp_stall), .stall_o (dec_stall), .valid_o (dec_valid),
        .region_o (dec_region), .is_read_o (dec_is_read), .word_idx_o (dec_word_idx),
        .data_o (dec_data), .bsel_o (dec_bsel),
        .rsp_addr_o (dec_rsp_addr), .rsp_modid_o (dec_rsp_modid)
    );

    mem_access_stage mem_stage_i (
        .clk_pm_i (clk_pm_i), .rst_n_i (rst_n_i),
        .valid_i (dec_valid), .region_i (dec_region), .is_read_i (dec_is_read),
        .word_idx_i (dec_word_idx), .data_i (dec_data), .bsel_i (dec_bsel),
        .rsp_addr_i (dec_rsp_addr), .rsp_modid_i (dec_rsp_modid),
        .stall_i (tx_q_stall), .stall_o (rsp_stall), .rsp_valid_o (rsp_valid),
        .rsp_data_o (rsp_data), .rsp_addr_o (rsp_addr), .rsp_modid_o (rsp_modid),
        .asm_en_o (asm_en_o), .acc_en_o (acc_en_o)
    );

    noc_tx_stage tx_stage_i (
        .clk_pm_i (clk_pm_i), .rst_n_i (rst_n_i),
        .valid_i (rsp_valid), .data_i (rsp_data), .addr_i (rsp_addr),
        .modid_i (rsp_modid), .tx_stall_i (tx_stall_i), .stall_o (tx_q_stall),
        .tx_wrreq_o (tx_wrreq_o), .tx_mode_o (tx_mode_o), .tx_addr_o (tx_addr_o),
        .tx_data_o (tx_data_o), .tx_trg_modid_o (tx_trg_modid_o)
    );

endmodule

// ==== design/noc_tx_stage.sv ====
`timescale 1ns/1ps
`include "tile_config.svh"

module noc_tx_stage (
    input  logic                   clk_pm_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  tile_pkg::noc_data_t    data_i,
    input  tile_pkg::noc_addr_t    addr_i,
    input  tile_pkg::noc_modid_t   modid_i,
    input  logic                   tx_stall_i,
    output logic                   stall_o,
    output logic                   tx_wrreq_o,
    output tile_pkg::noc_mode_t    tx_mode_o,
    output tile_pkg::noc_addr_t    tx_addr_o,
    output tile_pkg::noc_data_t    tx_data_o,
    output tile_pkg::noc_modid_t   tx_trg_modid_o
);

    logic wrreq_q;

    assign stall_o    = wrreq_q && tx_stall_i;
    assign tx_wrreq_o = wrreq_q;
    assign tx_mode_o  = `MODE_READ_RESP;   // only responses leave the tile

    always_ff @(posedge clk_pm_i) begin
        if (!rst_n_i) begin
            wrreq_q <= 1'b0;
        end else if (!stall_o) begin
            wrreq_q <= valid_i;
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (valid_i && !stall_o) begin
            tx_addr_o      <= addr_i;
            tx_data_o      <= data_i;
            tx_trg_modid_o <= modid_i;   // back to the requester
        end
    end

    // the memory stage must keep a blocked response steady
    a_rsp_hold: assert property (@(posedge clk_pm_i) disable iff (!rst_n_i)
        valid_i && stall_o |=> valid_i && $stable(data_i) && $stable(addr_i) &&
            $stable(modid_i))
        else $error("response changed while stalled");

endmodule

// ==== design/mem_access_stage.sv ====
`timescale 1ns/1ps
`include "tile_config.svh"

module mem_access_stage (
    input  logic                   clk_pm_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  tile_pkg::region_t      region_i,
    input  logic                   is_read_i,
    input  tile_pkg::noc_addr_t    word_idx_i,
    input  tile_pkg::noc_data_t    data_i,
    input  tile_pkg::noc_bsel_t    bsel_i,
    input  tile_pkg::noc_addr_t    rsp_addr_i,
    input  tile_pkg::noc_modid_t   rsp_modid_i,
    input  logic                   stall_i,
    output logic                   stall_o,
    output logic                   rsp_valid_o,
    output tile_pkg::noc_data_t    rsp_data_o,
    output tile_pkg::noc_addr_t    rsp_addr_o,
    output tile_pkg::noc_modid_t   rsp_modid_o,
    output logic                   asm_en_o,
    output logic                   acc_en_o
);

    logic                 rsp_valid_q;
    logic                 advance;
    logic                 dmem_en;
    logic                 accm_en;
    logic                 cfg_en;
    tile_pkg::region_t    rsp_region_q;
    tile_pkg::dmem_word_t dmem_rdata;
    tile_pkg::acc_word_t  accm_rdata;
    tile_pkg::noc_data_t  cfg_rdata;

    // a blocked response keeps the banks idle so their output holds
    assign stall_o = rsp_valid_q && stall_i;
    assign advance = valid_i && !stall_o;
    assign dmem_en = advance && (region_i == tile_pkg::DMEM);
    assign accm_en = advance && (region_i == tile_pkg::ACCMEM);
    assign cfg_en  = advance && (region_i == tile_pkg::CONFIG);

    spm_bank #(.word_t(tile_pkg::dmem_word_t), .DEPTH(`DMEM_WORDS)) dmem_i (
        .clk_pm_i (clk_pm_i),
        .en_i     (dmem_en),
        .we_i     (!is_read_i),
        .wben_i   (bsel_i),
        .idx_i    (word_idx_i),
        .wdata_i  (data_i),
        .rdata_o  (dmem_rdata)
    );

    spm_bank #(.word_t(tile_pkg::acc_word_t), .DEPTH(`ACCMEM_WORDS)) accmem_i (
        .clk_pm_i (clk_pm_i),
        .en_i     (accm_en),
        .we_i     (!is_read_i),
        .wben_i   (bsel_i),
        .idx_i    (word_idx_i),
        .wdata_i  (data_i[`ACC_WORD_BITS-1:0]),
        .rdata_o  (accm_rdata)
    );

    tile_regfile regfile_i (
        .clk_pm_i    (clk_pm_i),
        .rst_n_i     (rst_n_i),
        .en_i        (cfg_en),
        .we_i        (!is_read_i),
        .reg_sel_i   (word_idx_i[0]),
        .wdata_i     (data_i),
        .mem_write_i ((dmem_en || accm_en) && !is_read_i),
        .rdata_o     (cfg_rdata),
        .asm_en_o    (asm_en_o),
        .acc_en_o    (acc_en_o)
    );

    always_ff @(posedge clk_pm_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (!stall_o) begin
            rsp_valid_q <= valid_i && is_read_i;   // writes end here
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (advance) begin
            rsp_region_q <= region_i;
            rsp_addr_o   <= rsp_addr_i;
            rsp_modid_o  <= rsp_modid_i;
        end
    end

    always_comb begin
        case (rsp_region_q)
            tile_pkg::DMEM:   rsp_data_o = dmem_rdata;
            tile_pkg::ACCMEM: rsp_data_o = tile_pkg::noc_data_t'(accm_rdata);
            tile_pkg::CONFIG: rsp_data_o = cfg_rdata;
            default:          rsp_data_o = '0;   // unmapped reads answer zero
        endcase
    end

    assign rsp_valid_o = rsp_valid_q;

    // decode must hold a stalled item unchanged
    a_in_hold: assert property (@(posedge clk_pm_i) disable iff (!rst_n_i)
        valid_i && stall_o |=> valid_i && $stable(region_i) && $stable(is_read_i) &&
            $stable(word_idx_i) && $stable(data_i) && $stable(bsel_i) &&
            $stable(rsp_addr_i) && $stable(rsp_modid_i))
        else $error("decoded item changed while stalled");

endmodule

// ==== design/tile_regfile.sv ====
`timescale 1ns/1ps

module tile_regfile (
    input  logic                 clk_pm_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 we_i,
    input  logic                 reg_sel_i,
    input  tile_pkg::noc_data_t  wdata_i,
    input  logic                 mem_write_i,
    output tile_pkg::noc_data_t  rdata_o,
    output logic                 asm_en_o,
    output logic                 acc_en_o
);

    logic [1:0]  core_ctrl_q;  // bit0 asm, bit1 acc
    logic [15:0] wr_cnt_q;

    always_ff @(posedge clk_pm_i) begin
        if (!rst_n_i) begin
            core_ctrl_q <= '0;
        end else if (en_i && we_i && !reg_sel_i) begin
            core_ctrl_q <= wdata_i[1:0];
        end
    end

    // counts bank writes and wraps
    always_ff @(posedge clk_pm_i) begin
        if (!rst_n_i) begin
            wr_cnt_q <= '0;
        end else if (mem_write_i) begin
            wr_cnt_q <= wr_cnt_q + 16'd1;
        end
    end

    // registered like the banks so the mem stage can align it
    always_ff @(posedge clk_pm_i) begin
        if (en_i) begin
            if (reg_sel_i) begin
                rdata_o <= tile_pkg::noc_data_t'(wr_cnt_q);
            end else begin
                rdata_o <= tile_pkg::noc_data_t'(core_ctrl_q);
            end
        end
    end

    assign asm_en_o = core_ctrl_q[0];
    assign acc_en_o = core_ctrl_q[1];

endmodule

// ==== design/spm_bank.sv ====
`timescale 1ns/1ps

module spm_bank #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 256
) (
    input  logic                 clk_pm_i,
    input  logic                 en_i,
    input  logic                 we_i,
    input  tile_pkg::noc_bsel_t  wben_i,
    input  tile_pkg::noc_addr_t  idx_i,
    input  word_t                wdata_i,
    output word_t                rdata_o
);

    localparam int BYTES = $bits(word_t) / 8;
    localparam int AW    = $clog2(DEPTH);

    word_t mem [DEPTH];

    always_ff @(posedge clk_pm_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (wben_i[b]) begin
                        mem[idx_i[AW-1:0]][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            rdata_o <= mem[idx_i[AW-1:0]];   // read-first
        end
    end

    // decode must never hand us an index past the end
    a_idx_range: assert property (@(posedge clk_pm_i) en_i |-> idx_i < DEPTH)
        else $error("bank index out of range");

endmodule

// ==== design/tcu_cmd_decode.sv ====
`timescale 1ns/1ps
`include "tile_config.svh"

module tcu_cmd_decode (
    input  logic                   clk_pm_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  tile_pkg::noc_mode_t    mode_i,
    input  tile_pkg::noc_addr_t    addr_i,
    input  tile_pkg::noc_data_t    data_i,
    input  tile_pkg::noc_bsel_t    bsel_i,
    input  tile_pkg::noc_modid_t   src_modid_i,
    input  logic                   stall_i,
    output logic                   stall_o,
    output logic                   valid_o,
    output tile_pkg::region_t      region_o,
    output logic                   is_read_o,
    output tile_pkg::noc_addr_t    word_idx_o,
    output tile_pkg::noc_data_t    data_o,
    output tile_pkg::noc_bsel_t    bsel_o,
    output tile_pkg::noc_addr_t    rsp_addr_o,
    output tile_pkg::noc_modid_t   rsp_modid_o
);

    logic                valid_q;
    logic                known_mode;
    tile_pkg::noc_addr_t dmem_off;
    tile_pkg::noc_addr_t acc_off;
    tile_pkg::noc_addr_t cfg_off;
    tile_pkg::region_t   region_c;
    tile_pkg::noc_addr_t word_idx_c;

    assign known_mode = (mode_i == `MODE_WRITE) || (mode_i == `MODE_READ_REQ);
    assign dmem_off   = addr_i - `DMEM_START;
    assign acc_off    = addr_i - `ACCMEM_START;
    assign cfg_off    = addr_i - `CONFIG_START;

    // offsets wrap below each start, so one compare covers the range
    always_comb begin
        region_c   = tile_pkg::UNMAPPED;
        word_idx_c = '0;
        if (known_mode && dmem_off < `DMEM_WORDS * 8) begin
            region_c   = tile_pkg::DMEM;
            word_idx_c = dmem_off >> 3;
        end else if (known_mode && acc_off < `ACCMEM_WORDS * 4) begin
            region_c   = tile_pkg::ACCMEM;
            word_idx_c = acc_off >> 2;
        end else if (known_mode && cfg_off < `CONFIG_REGS * 8) begin
            region_c   = tile_pkg::CONFIG;
            word_idx_c = cfg_off >> 3;   // 8-byte registers
        end
    end

    assign stall_o = valid_q && stall_i;
    assign valid_o = valid_q;

    always_ff @(posedge clk_pm_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (!stall_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (valid_i && !stall_o) begin
            region_o    <= region_c;
            is_read_o   <= (mode_i == `MODE_READ_REQ);
            word_idx_o  <= word_idx_c;
            data_o      <= data_i;
            bsel_o      <= bsel_i;
            rsp_addr_o  <= addr_i;   // response echoes the request address
            rsp_modid_o <= src_modid_i;
        end
    end

endmodule

// ==== design/noc_rx_stage.sv ====
`timescale 1ns/1ps
`include "tile_config.svh"

module noc_rx_stage (
    input  logic                   clk_pm_i,
    input  logic                   rst_n_i,
    input  logic                   rx_wrreq_i,
    input  tile_pkg::noc_mode_t    rx_mode_i,
    input  tile_pkg::noc_addr_t    rx_addr_i,
    input  tile_pkg::noc_data_t    rx_data_i,
    input  tile_pkg::noc_bsel_t    rx_bsel_i,
    input  tile_pkg::noc_modid_t   rx_src_modid_i,
    input  tile_pkg::noc_modid_t   rx_trg_modid_i,
    input  logic                   stall_i,
    output logic                   rx_stall_o,
    output logic                   valid_o,
    output tile_pkg::noc_mode_t    mode_o,
    output tile_pkg::noc_addr_t    addr_o,
    output tile_pkg::noc_data_t    data_o,
    output tile_pkg::noc_bsel_t    bsel_o,
    output tile_pkg::noc_modid_t   src_modid_o
);

    logic valid_q;
    logic take;
    logic for_home;

    assign for_home   = (rx_trg_modid_i == `TILE_HOME_MODID);
    assign rx_stall_o = valid_q && stall_i;
    assign take       = rx_wrreq_i && !rx_stall_o && for_home;
    assign valid_o    = valid_q;

    always_ff @(posedge clk_pm_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (!rx_stall_o) begin
            valid_q <= take;   // foreign packets are swallowed here
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (take) begin
            mode_o      <= rx_mode_i;
            addr_o      <= rx_addr_i;
            data_o      <= rx_data_i;
            bsel_o      <= rx_bsel_i;
            src_modid_o <= rx_src_modid_i;
        end
    end

    // sender must hold its packet while we stall it
    a_rx_hold: assert property (@(posedge clk_pm_i) disable iff (!rst_n_i)
        rx_wrreq_i && rx_stall_o |=> rx_wrreq_i && $stable(rx_mode_i) &&
            $stable(rx_addr_i) && $stable(rx_data_i) && $stable(rx_bsel_i) &&
            $stable(rx_src_modid_i) && $stable(rx_trg_modid_i))
        else $error("rx packet changed while stalled");

endmodule

// ==== design/tile_pkg.sv ====
`include "tile_config.svh"

package tile_pkg;

    // noc packet fields
    typedef logic [`NOC_ADDR_BITS-1:0]  noc_addr_t;
    typedef logic [`NOC_DATA_BITS-1:0]  noc_data_t;
    typedef logic [`NOC_BSEL_BITS-1:0]  noc_bsel_t;
    typedef logic [`NOC_MODID_BITS-1:0] noc_modid_t;
    typedef logic [`NOC_MODE_BITS-1:0]  noc_mode_t;

    // scratchpad payloads
    typedef logic [`NOC_DATA_BITS-1:0]  dmem_word_t;
    typedef logic [`ACC_WORD_BITS-1:0]  acc_word_t;

    // target of a decoded command
    typedef enum logic [1:0] {
        DMEM,
        ACCMEM,
        CONFIG,
        UNMAPPED
    } region_t;

endpackage

// ==== include/tile_config.svh ====
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// packet field widths
`define NOC_ADDR_BITS   32
`define NOC_DATA_BITS   64
`define NOC_BSEL_BITS   8
`define NOC_MODID_BITS  8
`define NOC_MODE_BITS   4
`define ACC_WORD_BITS   32

`define TILE_HOME_MODID 8'h21

// address map in byte offsets
`define DMEM_START      32'h0000_0000
`define DMEM_WORDS      512
`define ACCMEM_START    32'h0000_1000
`define ACCMEM_WORDS    256
`define CONFIG_START    32'hF000_0000
`define CONFIG_REGS     2

`define MODE_WRITE      4'd0
`define MODE_READ_REQ   4'd1
`define MODE_READ_RESP  4'd2

`endif
